//--- uncore_defines.svh
`ifndef UNCORE_DEFINES_SVH
`define UNCORE_DEFINES_SVH

// Physical address and data word widths
`define UNC_ADDR_W 32
`define UNC_DATA_W 64

// Instruction side is requester 0, data side is requester 1
`define UNC_NUM_REQ 2

// Everything at or above this goes to external memory
`define UNC_DRAM_BASE 32'h8000_0000

// Device field of a local address
`define UNC_DEV_LSB 20
`define UNC_DEV_W 4

// Device number of the core-local interruptor
`define UNC_CLINT_DEV 1

// Register offsets live in the low address bits
`define UNC_OFS_W 16
`define UNC_MSIP_OFS 16'h0000
`define UNC_MTIMECMP_OFS 16'h4000
`define UNC_MTIME_OFS 16'hBFF8

`endif

//--- uncore_pkg.sv
`default_nettype none

`include "uncore_defines.svh"

package uncore_pkg;

  // Physical address
  typedef logic [`UNC_ADDR_W-1:0] addr_t;

  // One data word on every path
  typedef logic [`UNC_DATA_W-1:0] data_t;

  // Requester index carried with each command and response
  typedef logic [$clog2(`UNC_NUM_REQ)-1:0] req_id_t;

  // Device field of a local address
  typedef logic [`UNC_DEV_W-1:0] dev_t;

  // Register offset inside the timer block
  typedef logic [`UNC_OFS_W-1:0] ofs_t;

  // One-entry buffer occupancy
  typedef enum logic
  {
    BUF_EMPTY,
    BUF_FULL
  } buf_state_e;

  // Source picked by the response arbiter, highest priority first
  typedef enum logic [1:0]
  {
    SRC_MEM,
    SRC_CLINT,
    SRC_LOOP,
    SRC_NONE
  } resp_src_e;

endpackage

`default_nettype wire

//--- uncore_cmd_decode.sv
`default_nettype none

`include "uncore_defines.svh"

module uncore_cmd_decode
(
  input  logic                                   clk_i,
  input  logic                                   rst_i,

  input  logic [`UNC_NUM_REQ-1:0]                cmd_v_i,
  input  logic [`UNC_NUM_REQ-1:0]                cmd_write_i,
  input  uncore_pkg::addr_t [`UNC_NUM_REQ-1:0]   cmd_addr_i,
  input  uncore_pkg::data_t [`UNC_NUM_REQ-1:0]   cmd_data_i,
  output logic [`UNC_NUM_REQ-1:0]                cmd_ready_o,

  output logic                                   mem_cmd_v_o,
  input  logic                                   mem_cmd_ready_i,
  output logic                                   clint_cmd_v_o,
  input  logic                                   clint_cmd_ready_i,
  output logic                                   loop_cmd_v_o,
  input  logic                                   loop_cmd_ready_i,

  output logic                                   sel_write_o,
  output uncore_pkg::addr_t                      sel_addr_o,
  output uncore_pkg::data_t                      sel_data_o,
  output uncore_pkg::req_id_t                    sel_id_o
);

  import uncore_pkg::*;

  buf_state_e state_q;
  buf_state_e state_d;
  req_id_t    grant_id;
  logic       grant_v;
  logic       accept;
  logic       dest_fire;
  logic       is_local;
  logic       is_clint;
  dev_t       dev;

  // Fixed priority, lowest requester id wins
  always_comb
  begin
    grant_id = '0;
    grant_v  = 1'b0;
    for (int i = `UNC_NUM_REQ-1; i >= 0; i--)
    begin
      if (cmd_v_i[i])
      begin
        grant_id = req_id_t'(i);
        grant_v  = 1'b1;
      end
    end
  end

  // Only the winner sees ready, and only while the buffer is empty
  assign cmd_ready_o = (state_q == BUF_EMPTY && grant_v)
                       ? (`UNC_NUM_REQ'(1) << grant_id) : '0;
  assign accept      = |(cmd_v_i & cmd_ready_o);

  always_ff @(posedge clk_i)
  begin
    if (accept)
    begin
      sel_write_o <= cmd_write_i[grant_id];
      sel_addr_o  <= cmd_addr_i[grant_id];
      sel_data_o  <= cmd_data_i[grant_id];
      sel_id_o    <= grant_id;
    end
  end

  // Address decode of the buffered command
  assign dev      = sel_addr_o[`UNC_DEV_LSB +: `UNC_DEV_W];
  assign is_local = (sel_addr_o < `UNC_DRAM_BASE);
  assign is_clint = is_local && (dev == `UNC_DEV_W'(`UNC_CLINT_DEV));

  assign mem_cmd_v_o   = (state_q == BUF_FULL) && !is_local;
  assign clint_cmd_v_o = (state_q == BUF_FULL) && is_clint;
  assign loop_cmd_v_o  = (state_q == BUF_FULL) && is_local && !is_clint;

  assign dest_fire = (mem_cmd_v_o & mem_cmd_ready_i)
                   | (clint_cmd_v_o & clint_cmd_ready_i)
                   | (loop_cmd_v_o & loop_cmd_ready_i);

  always_comb
  begin
    case (state_q)
      BUF_EMPTY: state_d = accept ? BUF_FULL : BUF_EMPTY;
      BUF_FULL:  state_d = dest_fire ? BUF_EMPTY : BUF_FULL;
      default:   state_d = BUF_EMPTY;
    endcase
  end

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      state_q <= BUF_EMPTY;
    end
    else
    begin
      state_q <= state_d;
    end
  end

endmodule

`default_nettype wire

//--- uncore_clint.sv
`default_nettype none

`include "uncore_defines.svh"

module uncore_clint
(
  input  logic                  clk_i,
  input  logic                  rst_i,

  input  logic                  cmd_v_i,
  output logic                  cmd_ready_o,
  input  logic                  cmd_write_i,
  input  uncore_pkg::addr_t     cmd_addr_i,
  input  uncore_pkg::data_t     cmd_data_i,
  input  uncore_pkg::req_id_t   cmd_id_i,

  output logic                  resp_v_o,
  input  logic                  resp_ready_i,
  output uncore_pkg::data_t     resp_data_o,
  output uncore_pkg::req_id_t   resp_id_o,

  output logic                  timer_irq_o,
  output logic                  software_irq_o
);

  import uncore_pkg::*;

  data_t   mtime_q;
  data_t   mtimecmp_q;
  logic    msip_q;
  logic    resp_v_q;
  data_t   resp_data_q;
  req_id_t resp_id_q;

  ofs_t    cmd_ofs;
  logic    accept;
  logic    wr_msip;
  logic    wr_mtimecmp;
  logic    wr_mtime;
  data_t   rd_data;

  // One response in flight at a time
  assign cmd_ready_o = !resp_v_q;
  assign accept      = cmd_v_i && cmd_ready_o;
  assign cmd_ofs     = cmd_addr_i[`UNC_OFS_W-1:0];

  assign wr_msip     = accept && cmd_write_i && (cmd_ofs == `UNC_MSIP_OFS);
  assign wr_mtimecmp = accept && cmd_write_i && (cmd_ofs == `UNC_MTIMECMP_OFS);
  assign wr_mtime    = accept && cmd_write_i && (cmd_ofs == `UNC_MTIME_OFS);

  // Unknown offsets read as zero
  always_comb
  begin
    case (cmd_ofs)
      `UNC_MSIP_OFS:     rd_data = data_t'(msip_q);
      `UNC_MTIMECMP_OFS: rd_data = mtimecmp_q;
      `UNC_MTIME_OFS:    rd_data = mtime_q;
      default:           rd_data = '0;
    endcase
  end

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      mtime_q    <= '0;
      mtimecmp_q <= '1;
      msip_q     <= 1'b0;
    end
    else
    begin
      // A write to mtime takes precedence over the tick
      if (wr_mtime)
      begin
        mtime_q <= cmd_data_i;
      end
      else
      begin
        mtime_q <= mtime_q + data_t'(1);
      end
      if (wr_mtimecmp)
      begin
        mtimecmp_q <= cmd_data_i;
      end
      if (wr_msip)
      begin
        msip_q <= cmd_data_i[0];
      end
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      resp_v_q <= 1'b0;
    end
    else if (accept)
    begin
      resp_v_q <= 1'b1;
    end
    else if (resp_v_q && resp_ready_i)
    begin
      resp_v_q <= 1'b0;
    end
  end

  // Writes answer with zero data
  always_ff @(posedge clk_i)
  begin
    if (accept)
    begin
      resp_data_q <= cmd_write_i ? '0 : rd_data;
      resp_id_q   <= cmd_id_i;
    end
  end

  assign resp_v_o    = resp_v_q;
  assign resp_data_o = resp_data_q;
  assign resp_id_o   = resp_id_q;

  assign timer_irq_o    = (mtime_q >= mtimecmp_q);
  assign software_irq_o = msip_q;

endmodule

`default_nettype wire

//--- uncore_resp_route.sv
`default_nettype none

`include "uncore_defines.svh"

module uncore_resp_route
(
  input  logic                                   clk_i,
  input  logic                                   rst_i,

  input  logic                                   loop_cmd_v_i,
  output logic                                   loop_cmd_ready_o,
  input  uncore_pkg::req_id_t                    loop_cmd_id_i,

  input  logic                                   mem_resp_v_i,
  input  uncore_pkg::data_t                      mem_resp_data_i,
  input  uncore_pkg::req_id_t                    mem_resp_id_i,
  output logic                                   mem_resp_ready_o,

  input  logic                                   clint_resp_v_i,
  input  uncore_pkg::data_t                      clint_resp_data_i,
  input  uncore_pkg::req_id_t                    clint_resp_id_i,
  output logic                                   clint_resp_ready_o,

  output logic [`UNC_NUM_REQ-1:0]                resp_v_o,
  output uncore_pkg::data_t [`UNC_NUM_REQ-1:0]   resp_data_o,
  input  logic [`UNC_NUM_REQ-1:0]                resp_ready_i
);

  import uncore_pkg::*;

  buf_state_e loop_state_q;
  req_id_t    loop_id_q;
  logic       loop_resp_v;
  logic       taken;
  resp_src_e  grant_src;
  data_t      grant_data;
  req_id_t    grant_id;

  // Loopback holds only the id, its data is always zero
  assign loop_cmd_ready_o = (loop_state_q == BUF_EMPTY);
  assign loop_resp_v      = (loop_state_q == BUF_FULL);

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      loop_state_q <= BUF_EMPTY;
    end
    else if (loop_cmd_v_i && loop_cmd_ready_o)
    begin
      loop_state_q <= BUF_FULL;
    end
    else if (taken && grant_src == SRC_LOOP)
    begin
      loop_state_q <= BUF_EMPTY;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (loop_cmd_v_i && loop_cmd_ready_o)
    begin
      loop_id_q <= loop_cmd_id_i;
    end
  end

  // Memory first, then timer, then loopback
  always_comb
  begin
    grant_src  = SRC_NONE;
    grant_data = '0;
    grant_id   = '0;
    if (mem_resp_v_i)
    begin
      grant_src  = SRC_MEM;
      grant_data = mem_resp_data_i;
      grant_id   = mem_resp_id_i;
    end
    else if (clint_resp_v_i)
    begin
      grant_src  = SRC_CLINT;
      grant_data = clint_resp_data_i;
      grant_id   = clint_resp_id_i;
    end
    else if (loop_resp_v)
    begin
      grant_src = SRC_LOOP;
      grant_id  = loop_id_q;
    end
  end

  // Steer to the requester named by the id
  always_comb
  begin
    for (int i = 0; i < `UNC_NUM_REQ; i++)
    begin
      resp_v_o[i]    = (grant_src != SRC_NONE) && (grant_id == req_id_t'(i));
      resp_data_o[i] = grant_data;
    end
  end

  assign taken              = |(resp_v_o & resp_ready_i);
  assign mem_resp_ready_o   = taken && (grant_src == SRC_MEM);
  assign clint_resp_ready_o = taken && (grant_src == SRC_CLINT);

endmodule

`default_nettype wire

//--- uncore_top.sv
`default_nettype none

`include "uncore_defines.svh"

module uncore_top
(
  input  logic                                   clk_i,
  input  logic                                   rst_i,

  // Requester commands
  input  logic [`UNC_NUM_REQ-1:0]                cmd_v_i,
  input  logic [`UNC_NUM_REQ-1:0]                cmd_write_i,
  input  uncore_pkg::addr_t [`UNC_NUM_REQ-1:0]   cmd_addr_i,
  input  uncore_pkg::data_t [`UNC_NUM_REQ-1:0]   cmd_data_i,
  output logic [`UNC_NUM_REQ-1:0]                cmd_ready_o,

  // Requester responses
  output logic [`UNC_NUM_REQ-1:0]                resp_v_o,
  output uncore_pkg::data_t [`UNC_NUM_REQ-1:0]   resp_data_o,
  input  logic [`UNC_NUM_REQ-1:0]                resp_ready_i,

  // External memory
  output logic                                   mem_cmd_v_o,
  input  logic                                   mem_cmd_ready_i,
  output logic                                   mem_cmd_write_o,
  output uncore_pkg::addr_t                      mem_cmd_addr_o,
  output uncore_pkg::data_t                      mem_cmd_data_o,
  output uncore_pkg::req_id_t                    mem_cmd_id_o,
  input  logic                                   mem_resp_v_i,
  input  uncore_pkg::data_t                      mem_resp_data_i,
  input  uncore_pkg::req_id_t                    mem_resp_id_i,
  output logic                                   mem_resp_ready_o,

  output logic                                   timer_irq_o,
  output logic                                   software_irq_o
);

  import uncore_pkg::*;

  logic    sel_write;
  addr_t   sel_addr;
  data_t   sel_data;
  req_id_t sel_id;

  logic    clint_cmd_v;
  logic    clint_cmd_ready;
  logic    loop_cmd_v;
  logic    loop_cmd_ready;

  logic    clint_resp_v;
  data_t   clint_resp_data;
  req_id_t clint_resp_id;
  logic    clint_resp_ready;

  // The buffered command fans out to every destination
  assign mem_cmd_write_o = sel_write;
  assign mem_cmd_addr_o  = sel_addr;
  assign mem_cmd_data_o  = sel_data;
  assign mem_cmd_id_o    = sel_id;

  uncore_cmd_decode u_cmd_decode
  (
    .clk_i             (clk_i),
    .rst_i             (rst_i),
    .cmd_v_i           (cmd_v_i),
    .cmd_write_i       (cmd_write_i),
    .cmd_addr_i        (cmd_addr_i),
    .cmd_data_i        (cmd_data_i),
    .cmd_ready_o       (cmd_ready_o),
    .mem_cmd_v_o       (mem_cmd_v_o),
    .mem_cmd_ready_i   (mem_cmd_ready_i),
    .clint_cmd_v_o     (clint_cmd_v),
    .clint_cmd_ready_i (clint_cmd_ready),
    .loop_cmd_v_o      (loop_cmd_v),
    .loop_cmd_ready_i  (loop_cmd_ready),
    .sel_write_o       (sel_write),
    .sel_addr_o        (sel_addr),
    .sel_data_o        (sel_data),
    .sel_id_o          (sel_id)
  );

  uncore_clint u_clint
  (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .cmd_v_i        (clint_cmd_v),
    .cmd_ready_o    (clint_cmd_ready),
    .cmd_write_i    (sel_write),
    .cmd_addr_i     (sel_addr),
    .cmd_data_i     (sel_data),
    .cmd_id_i       (sel_id),
    .resp_v_o       (clint_resp_v),
    .resp_ready_i   (clint_resp_ready),
    .resp_data_o    (clint_resp_data),
    .resp_id_o      (clint_resp_id),
    .timer_irq_o    (timer_irq_o),
    .software_irq_o (software_irq_o)
  );

  uncore_resp_route u_resp_route
  (
    .clk_i              (clk_i),
    .rst_i              (rst_i),
    .loop_cmd_v_i       (loop_cmd_v),
    .loop_cmd_ready_o   (loop_cmd_ready),
    .loop_cmd_id_i      (sel_id),
    .mem_resp_v_i       (mem_resp_v_i),
    .mem_resp_data_i    (mem_resp_data_i),
    .mem_resp_id_i      (mem_resp_id_i),
    .mem_resp_ready_o   (mem_resp_ready_o),
    .clint_resp_v_i     (clint_resp_v),
    .clint_resp_data_i  (clint_resp_data),
    .clint_resp_id_i    (clint_resp_id),
    .clint_resp_ready_o (clint_resp_ready),
    .resp_v_o           (resp_v_o),
    .resp_data_o        (resp_data_o),
    .resp_ready_i       (resp_ready_i)
  );

endmodule

`default_nettype wire

//--- uncore_sva.sv
`default_nettype none

`include "uncore_defines.svh"

module uncore_sva
(
  input  logic                                   clk_i,
  input  logic                                   rst_i,
  input  logic [`UNC_NUM_REQ-1:0]                cmd_ready_i,
  input  logic                                   mem_cmd_v_i,
  input  logic                                   clint_cmd_v_i,
  input  logic                                   loop_cmd_v_i,
  input  logic [`UNC_NUM_REQ-1:0]                resp_v_i,
  input  uncore_pkg::data_t [`UNC_NUM_REQ-1:0]   resp_data_i,
  input  logic [`UNC_NUM_REQ-1:0]                resp_ready_i,
  input  uncore_pkg::resp_src_e                  grant_src_i
);

  timeunit 1ns;
  timeprecision 1ns;

  import uncore_pkg::*;

  // The command arbiter grants one requester at a time
  assert property (@(posedge clk_i) disable iff (rst_i) $onehot0(cmd_ready_i))
    else $error("More than one requester sees cmd_ready in the same cycle");

  // A decoded command has exactly one destination
  assert property (@(posedge clk_i) disable iff (rst_i)
    $onehot0({mem_cmd_v_i, clint_cmd_v_i, loop_cmd_v_i}))
    else $error("Command valid raised toward more than one destination");

  // A held response stays put unless a higher source takes the grant
  for (genvar i = 0; i < `UNC_NUM_REQ; i++)
  begin : g_hold
    assert property (@(posedge clk_i) disable iff (rst_i)
      (resp_v_i[i] && !resp_ready_i[i])
      |=> (grant_src_i < $past(grant_src_i)) || (resp_v_i[i] && $stable(resp_data_i[i])))
      else $error("Held response to requester %0d dropped or changed its data", i);
  end

endmodule

bind uncore_top uncore_sva u_sva
(
  .clk_i         (clk_i),
  .rst_i         (rst_i),
  .cmd_ready_i   (cmd_ready_o),
  .mem_cmd_v_i   (mem_cmd_v_o),
  .clint_cmd_v_i (clint_cmd_v),
  .loop_cmd_v_i  (loop_cmd_v),
  .resp_v_i      (resp_v_o),
  .resp_data_i   (resp_data_o),
  .resp_ready_i  (resp_ready_i),
  .grant_src_i   (u_resp_route.grant_src)
);

`default_nettype wire

//--- uncore_tb.sv
`default_nettype none

`include "uncore_defines.svh"

module uncore_tb;

  timeunit 1ns;
  timeprecision 1ns;

  import uncore_pkg::*;

  // The directed tests need roughly 500 cycles
  localparam int test_cycles = 500;
  localparam int cycle_limit = 4 * test_cycles;

  localparam addr_t dram_base     = `UNC_DRAM_BASE;
  localparam addr_t clint_base    = addr_t'(`UNC_CLINT_DEV) << `UNC_DEV_LSB;
  localparam addr_t msip_addr     = clint_base | addr_t'(`UNC_MSIP_OFS);
  localparam addr_t mtimecmp_addr = clint_base | addr_t'(`UNC_MTIMECMP_OFS);
  localparam addr_t mtime_addr    = clint_base | addr_t'(`UNC_MTIME_OFS);
  localparam addr_t unmapped_addr = (addr_t'(3) << `UNC_DEV_LSB) | addr_t'(`UNC_MTIMECMP_OFS);

  logic                     clk;
  logic                     rst;
  logic [`UNC_NUM_REQ-1:0]  cmd_v;
  logic [`UNC_NUM_REQ-1:0]  cmd_write;
  addr_t [`UNC_NUM_REQ-1:0] cmd_addr;
  data_t [`UNC_NUM_REQ-1:0] cmd_data;
  logic [`UNC_NUM_REQ-1:0]  cmd_ready;
  logic [`UNC_NUM_REQ-1:0]  resp_v;
  data_t [`UNC_NUM_REQ-1:0] resp_data;
  logic [`UNC_NUM_REQ-1:0]  resp_ready;

  logic    mem_cmd_v;
  logic    mem_cmd_ready = 1'b0;
  logic    mem_cmd_write;
  addr_t   mem_cmd_addr;
  data_t   mem_cmd_data;
  req_id_t mem_cmd_id;
  logic    mem_resp_v = 1'b0;
  data_t   mem_resp_data = '0;
  req_id_t mem_resp_id = '0;
  logic    mem_resp_ready;
  logic    timer_irq;
  logic    software_irq;

  // Memory contents and a log of the commands seen on the memory port
  data_t       mem [addr_t];
  int unsigned mem_wait = 0;
  logic [3:0]  mem_count = '0;
  logic        seen_write [16];
  addr_t       seen_addr [16];
  data_t       seen_data [16];
  req_id_t     seen_id [16];

  int err_value = 0;
  int err_other = 0;
  int cycles = 0;

  uncore_top dut
  (
    .clk_i            (clk),
    .rst_i            (rst),
    .cmd_v_i          (cmd_v),
    .cmd_write_i      (cmd_write),
    .cmd_addr_i       (cmd_addr),
    .cmd_data_i       (cmd_data),
    .cmd_ready_o      (cmd_ready),
    .resp_v_o         (resp_v),
    .resp_data_o      (resp_data),
    .resp_ready_i     (resp_ready),
    .mem_cmd_v_o      (mem_cmd_v),
    .mem_cmd_ready_i  (mem_cmd_ready),
    .mem_cmd_write_o  (mem_cmd_write),
    .mem_cmd_addr_o   (mem_cmd_addr),
    .mem_cmd_data_o   (mem_cmd_data),
    .mem_cmd_id_o     (mem_cmd_id),
    .mem_resp_v_i     (mem_resp_v),
    .mem_resp_data_i  (mem_resp_data),
    .mem_resp_id_i    (mem_resp_id),
    .mem_resp_ready_o (mem_resp_ready),
    .timer_irq_o      (timer_irq),
    .software_irq_o   (software_irq)
  );

  initial
  begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Unwritten memory reads back a pattern built from its address
  function automatic data_t fill_word(input addr_t addr);
    return {~addr, addr ^ 32'h5a5a_a5a5};
  endfunction

  function automatic data_t read_word(input addr_t addr);
    if (mem.exists(addr))
    begin
      return mem[addr];
    end
    return fill_word(addr);
  endfunction

  // One command at a time, answered after 1 to 4 cycles
  always @(posedge clk)
  begin
    if (rst)
    begin
      mem_cmd_ready <= 1'b1;
      mem_resp_v    <= 1'b0;
      mem_wait      <= 0;
    end
    else if (mem_cmd_v && mem_cmd_ready)
    begin
      mem_cmd_ready <= 1'b0;
      mem_wait      <= 1 + ($urandom % 4);
      mem_resp_id   <= mem_cmd_id;
      mem_resp_data <= mem_cmd_write ? '0 : read_word(mem_cmd_addr);
      if (mem_cmd_write)
      begin
        mem[mem_cmd_addr] = mem_cmd_data;
      end
      seen_write[mem_count] <= mem_cmd_write;
      seen_addr[mem_count]  <= mem_cmd_addr;
      seen_data[mem_count]  <= mem_cmd_data;
      seen_id[mem_count]    <= mem_cmd_id;
      mem_count             <= mem_count + 4'd1;
    end
    else if (mem_wait != 0)
    begin
      mem_wait <= mem_wait - 1;
      if (mem_wait == 1)
      begin
        mem_resp_v <= 1'b1;
      end
    end
    else if (mem_resp_v && mem_resp_ready)
    begin
      mem_resp_v    <= 1'b0;
      mem_cmd_ready <= 1'b1;
    end
  end

  always @(posedge clk)
  begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit)
    begin
      $display("Timeout after %0d cycles, a handshake never completed", cycles);
      $display("Finished with errors");
      $finish;
    end
  end

  task automatic check_data(input string test, input data_t exp, input data_t act);
    if (act !== exp)
    begin
      err_value++;
      $display("Fail %s: expected %h, actual %h", test, exp, act);
    end
  endtask

  task automatic check_id(input string test, input req_id_t exp, input req_id_t act);
    if (act !== exp)
    begin
      err_value++;
      $display("Fail %s: expected id %0d, actual id %0d", test, exp, act);
    end
  endtask

  task automatic check_addr(input string test, input addr_t exp, input addr_t act);
    if (act !== exp)
    begin
      err_value++;
      $display("Fail %s: expected address %h, actual %h", test, exp, act);
    end
  endtask

  task automatic check_flag(input string test, input logic exp, input logic act);
    if (act !== exp)
    begin
      err_value++;
      $display("Fail %s: expected %b, actual %b", test, exp, act);
    end
  endtask

  // Hold the command until the arbiter takes it
  task automatic issue(input req_id_t id, input logic wr, input addr_t addr, input data_t wdata);
    @(posedge clk);
    cmd_v[id]     <= 1'b1;
    cmd_write[id] <= wr;
    cmd_addr[id]  <= addr;
    cmd_data[id]  <= wdata;
    @(posedge clk);
    while (!cmd_ready[id])
    begin
      @(posedge clk);
    end
    cmd_v[id] <= 1'b0;
  endtask

  task automatic collect(input req_id_t id, input bit exclusive, output data_t data);
    req_id_t other;
    other = id ^ req_id_t'(1);
    resp_ready[id] <= 1'b1;
    @(posedge clk);
    while (!resp_v[id])
    begin
      if (exclusive && resp_v[other])
      begin
        err_other++;
        $display("Response meant for requester %0d showed up on requester %0d", id, other);
      end
      @(posedge clk);
    end
    data = resp_data[id];
    resp_ready[id] <= 1'b0;
  endtask

  task automatic access(input req_id_t id, input logic wr, input addr_t addr,
                        input data_t wdata, input bit exclusive, output data_t rdata);
    issue(id, wr, addr, wdata);
    collect(id, exclusive, rdata);
  endtask

  task automatic test_reset_state();
    @(posedge clk);
    check_flag("reset cmd_ready", 1'b0, |cmd_ready);
    check_flag("reset resp_v", 1'b0, |resp_v);
    check_flag("reset mem_cmd_v", 1'b0, mem_cmd_v);
    check_flag("reset timer_irq", 1'b0, timer_irq);
    check_flag("reset software_irq", 1'b0, software_irq);
  endtask

  task automatic test_dram_rw();
    addr_t      addr;
    data_t      wdata;
    data_t      rdata;
    logic [3:0] base;
    addr  = dram_base + addr_t'(32'h100);
    wdata = {$urandom, $urandom};
    base  = mem_count;
    access(0, 1'b1, addr, wdata, 1'b1, rdata);
    check_data("dram_rw write response", '0, rdata);
    check_flag("dram_rw mem write", 1'b1, seen_write[base]);
    check_addr("dram_rw mem addr", addr, seen_addr[base]);
    check_data("dram_rw mem data", wdata, seen_data[base]);
    check_id("dram_rw mem id", 0, seen_id[base]);
    access(0, 1'b0, addr, '0, 1'b1, rdata);
    check_data("dram_rw read data", wdata, rdata);
    check_id("dram_rw read id", 0, seen_id[base + 4'd1]);
  endtask

  task automatic test_dram_req1();
    addr_t      addr;
    data_t      rdata;
    logic [3:0] base;
    addr = dram_base + addr_t'(32'h2468);
    base = mem_count;
    access(1, 1'b0, addr, '0, 1'b1, rdata);
    check_data("dram_req1 read data", fill_word(addr), rdata);
    check_id("dram_req1 mem id", 1, seen_id[base]);
  endtask

  task automatic test_msip();
    data_t rdata;
    access(1, 1'b1, msip_addr, data_t'(1), 1'b1, rdata);
    check_flag("msip set irq", 1'b1, software_irq);
    access(0, 1'b0, msip_addr, '0, 1'b1, rdata);
    check_data("msip read", data_t'(1), rdata);
    access(1, 1'b1, msip_addr, '0, 1'b1, rdata);
    check_flag("msip clear irq", 1'b0, software_irq);
  endtask

  task automatic test_mtime();
    data_t t0;
    data_t t1;
    data_t rdata;
    check_flag("mtime irq before compare", 1'b0, timer_irq);
    access(0, 1'b0, mtime_addr, '0, 1'b1, t0);
    access(1, 1'b0, mtime_addr, '0, 1'b1, t1);
    if (!(t1 > t0))
    begin
      err_other++;
      $display("mtime did not advance between reads: %h then %h", t0, t1);
    end
    access(0, 1'b1, mtimecmp_addr, t1, 1'b1, rdata);
    check_flag("mtime irq after compare", 1'b1, timer_irq);
    // Park the compare value again so the interrupt drops
    access(0, 1'b1, mtimecmp_addr, '1, 1'b1, rdata);
    check_flag("mtime irq after restore", 1'b0, timer_irq);
  endtask

  // Live timer offsets under another device field must still read zero
  task automatic test_unmapped();
    data_t rdata;
    access(1, 1'b0, unmapped_addr, '0, 1'b1, rdata);
    check_data("unmapped dev3 req1", '0, rdata);
    access(0, 1'b0, addr_t'(`UNC_MTIME_OFS), '0, 1'b1, rdata);
    check_data("unmapped dev0 req0", '0, rdata);
  endtask

  task automatic test_dual();
    addr_t      a0;
    addr_t      a1;
    data_t      d0;
    data_t      d1;
    data_t      rd0;
    data_t      rd1;
    logic [3:0] base;
    a0 = dram_base + addr_t'(32'h400);
    a1 = dram_base + addr_t'(32'h808);
    d0 = {$urandom, $urandom};
    d1 = {$urandom, $urandom};
    access(0, 1'b1, a0, d0, 1'b1, rd0);
    access(1, 1'b1, a1, d1, 1'b1, rd1);
    base = mem_count;
    fork
      access(0, 1'b0, a0, '0, 1'b0, rd0);
      access(1, 1'b0, a1, '0, 1'b0, rd1);
    join
    check_id("dual first on memory", 0, seen_id[base]);
    check_id("dual second on memory", 1, seen_id[base + 4'd1]);
    check_data("dual req0 data", d0, rd0);
    check_data("dual req1 data", d1, rd1);
  endtask

  initial
  begin
    void'($urandom(77271));
    rst        <= 1'b1;
    cmd_v      <= '0;
    cmd_write  <= '0;
    cmd_addr   <= '0;
    cmd_data   <= '0;
    resp_ready <= '0;
    repeat (8) @(posedge clk);
    rst <= 1'b0;
    test_reset_state();
    test_dram_rw();
    test_dram_req1();
    test_msip();
    test_mtime();
    test_unmapped();
    test_dual();
    repeat (4) @(posedge clk);
    $display("Errors: %0d value mismatches, %0d other failures", err_value, err_other);
    if (err_value + err_other == 0)
    begin
      $display("Finished with no errors");
    end
    else
    begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- flist.f
+incdir+.
uncore_pkg.sv
uncore_cmd_decode.sv
uncore_clint.sv
uncore_resp_route.sv
uncore_top.sv
uncore_sva.sv
uncore_tb.sv

//--- run.sh
#!/bin/sh
# Build the uncore testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timescale 1ns/1ns --top-module uncore_tb \
    -f flist.f -o uncore_sim \
  && ./obj_dir/uncore_sim | tee /dev/stderr | grep -q "Finished with no errors" \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }
